/* Makefile */
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_memctl
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the binary exits non-zero on a fatal check, the log decides the result
sim: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/memctl_trace.txt */
# W addr beats, then one data word per beat
# R addr beats, then per beat: 36-bit flip mask, expected data, expected lane flags
# mask bit 9*lane+k flips data bit k of that lane for k below 8, bit 9*lane+8 is its parity
W 00010 4 11223344 a5a5a5a5 00000000 ffffffff
R 00010 4
  000000000 11223344 0
  000000000 a5a5a5a5 0
  000000000 00000000 0
  000000000 ffffffff 0
# longest burst, then a single beat straight after it
W 00100 7 01234567 89abcdef deadbeef cafef00d 0f1e2d3c 4b5a6978 87654321
W 00200 1 5a5a5a5a
# one bad bit per beat, except beat 3 with two flips in lane 2
R 00100 7
  000000001 01234566 1
  000000100 89abcdef 1
  000001000 deadb6ef 2
  0000c0000 cafdf00d 0
  400000000 8f1e2d3c 8
  800000000 4b5a6978 8
  008040201 86644220 f
R 00200 1 000000000 5a5a5a5a 0
W 00300 3 00000001 00000100 80000000
R 00300 3
  000000000 00000001 0
  000000000 00000100 0
  000000000 80000000 0
# single-beat reads may follow each other with no gap
R 00010 1 000000000 11223344 0
R 00013 1 000000000 ffffffff 0
# data bit and parity bit of lane 0 both flipped, even parity misses it
R 00012 2
  000000101 00000001 0
  000000000 ffffffff 0
# overwrite of an earlier word
W 00010 1 cafebabe
R 00010 1 000000000 cafebabe 0

/* bench/tb_clkgen.sv */
// clock runs from time zero with no stop; reset is released on a rising edge and never asserted again
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic rst
);

	// 20 ns period, first rising edge at 10 ns
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// synchronous reset, seen by the DUT on five rising edges
	initial
	begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* bench/tb_memctl.sv */
// run from the project root so the trace path resolves; the SRAM model has a fixed 3-cycle read latency
`timescale 1ns/1ps

module tb_memctl;

	logic              clk;
	logic              rst;
	logic              avl_write_req = 1'b0;
	logic              avl_read_req = 1'b0;
	memctl_pkg::addr_t avl_addr = '0;
	memctl_pkg::size_t avl_size = '0;
	memctl_pkg::data_t avl_wdata = '0;
	logic              avl_ready;
	logic              avl_rdata_valid;
	memctl_pkg::data_t avl_rdata;
	memctl_pkg::perr_t avl_parity_error;
	logic              mem_write;
	logic              mem_read;
	memctl_pkg::addr_t mem_addr;
	memctl_pkg::enc_t  mem_wdata;
	logic              mem_rdata_valid = 1'b0;
	memctl_pkg::enc_t  mem_rdata = '0;

	// trace contents, one entry per burst and one per beat
	logic [7:0]        line_kind[$];
	memctl_pkg::addr_t line_addr[$];
	memctl_pkg::size_t line_size[$];
	memctl_pkg::data_t beat_word[$];
	memctl_pkg::enc_t  beat_mask[$];
	memctl_pkg::data_t beat_exp_data[$];
	memctl_pkg::perr_t beat_exp_perr[$];
	int                beat_count = 0;

	// memory commands still owed by the DUT, with the edge they must be seen on
	bit                exp_is_read[$];
	memctl_pkg::addr_t exp_addr[$];
	memctl_pkg::enc_t  exp_enc[$];
	int                exp_cycle[$];

	// read return still owed, and the flip masks the SRAM model applies in order
	memctl_pkg::data_t exp_ret_data[$];
	memctl_pkg::perr_t exp_ret_perr[$];
	memctl_pkg::enc_t  mask_q[$];

	int   cycle = 0;
	int   cycle_limit = 0;
	int   ready_low_left = 0;
	logic prev_mem_valid = 1'b0;

	// SRAM contents and its latency pipe
	memctl_pkg::enc_t  sram[memctl_pkg::addr_t];
	logic              s1_valid;
	logic              s2_valid;
	memctl_pkg::enc_t  s1_data;
	memctl_pkg::enc_t  s2_data;

	tb_clkgen u_clkgen (
		.clk (clk),
		.rst (rst)
	);

	memctl_top DUT (
		.clk              (clk),
		.rst              (rst),
		.avl_write_req    (avl_write_req),
		.avl_read_req     (avl_read_req),
		.avl_addr         (avl_addr),
		.avl_size         (avl_size),
		.avl_wdata        (avl_wdata),
		.avl_ready        (avl_ready),
		.avl_rdata_valid  (avl_rdata_valid),
		.avl_rdata        (avl_rdata),
		.avl_parity_error (avl_parity_error),
		.mem_write        (mem_write),
		.mem_read         (mem_read),
		.mem_addr         (mem_addr),
		.mem_wdata        (mem_wdata),
		.mem_rdata_valid  (mem_rdata_valid),
		.mem_rdata        (mem_rdata)
	);

	//////////////////////////////////////////////////////////////////////
	// failure reporting and compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			abort_run("a strobe or level on the DUT is wrong");
		end
	endtask

	task automatic check_data(input string name, input memctl_pkg::data_t exp,
		input memctl_pkg::data_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			abort_run("a data word from the DUT is wrong");
		end
	endtask

	task automatic check_perr(input string name, input memctl_pkg::perr_t exp,
		input memctl_pkg::perr_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			abort_run("the lane parity flags from the DUT are wrong");
		end
	endtask

	task automatic check_addr(input string name, input memctl_pkg::addr_t exp,
		input memctl_pkg::addr_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			abort_run("a memory address from the DUT is wrong");
		end
	endtask

	task automatic check_enc(input string name, input memctl_pkg::enc_t exp,
		input memctl_pkg::enc_t act);
		if (act !== exp)
		begin
			$display("Fail %s: expected %h, got %h", name, exp, act);
			abort_run("an encoded memory word from the DUT is wrong");
		end
	endtask

	// each byte keeps its bits and gets an even-parity bit as its ninth bit
	function automatic memctl_pkg::enc_t encode_word(input memctl_pkg::data_t word);
		memctl_pkg::enc_t enc;
		logic             par;
		enc = '0;
		for (int b = 0; b < memctl_pkg::NUM_BYTES; b++)
		begin
			par = 1'b0;
			for (int k = 0; k < 8; k++)
			begin
				enc[b*9 + k] = word[b*8 + k];
				par = par ^ word[b*8 + k];
			end
			enc[b*9 + 8] = par;
		end
		return enc;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// trace reading and stimulus
	//////////////////////////////////////////////////////////////////////

	// bursts are read token by token, so read beats may sit on their own lines
	task automatic load_trace();
		int                fd;
		int                code;
		int                ch;
		logic [7:0]        kind;
		memctl_pkg::addr_t addr;
		memctl_pkg::size_t size;
		memctl_pkg::data_t word;
		memctl_pkg::enc_t  mask;
		memctl_pkg::perr_t perr;
		fd = $fopen("bench/memctl_trace.txt", "r");
		if (fd == 0)
		begin
			abort_run("cannot open the trace file bench/memctl_trace.txt");
		end
		code = $fscanf(fd, " %c", kind);
		while (code == 1)
		begin
			if (kind == "#")
			begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
				begin
					ch = $fgetc(fd);
				end
			end
			else if (kind == "W" || kind == "R")
			begin
				code = $fscanf(fd, " %h %h", addr, size);
				if (code != 2 || size == '0)
				begin
					abort_run("the trace holds a malformed burst header");
				end
				line_kind.push_back(kind);
				line_addr.push_back(addr);
				line_size.push_back(size);
				beat_count += int'(size);
				for (int n = 0; n < int'(size); n++)
				begin
					if (kind == "W")
					begin
						code = $fscanf(fd, " %h", word);
						beat_word.push_back(word);
					end
					else
					begin
						code = $fscanf(fd, " %h %h %h", mask, word, perr);
						beat_mask.push_back(mask);
						beat_exp_data.push_back(word);
						beat_exp_perr.push_back(perr);
						code = (code == 3) ? 1 : 0;
					end
					if (code != 1)
					begin
						abort_run("the trace ends inside a burst");
					end
				end
			end
			else
			begin
				abort_run("the trace holds a line of unknown kind");
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
	endtask

	task automatic drive_idle();
		@(posedge clk);
		avl_write_req <= 1'b0;
		avl_read_req  <= 1'b0;
	endtask

	// address and size only count on the first beat, later beats carry junk there
	task automatic drive_write(input memctl_pkg::addr_t addr, input memctl_pkg::size_t size,
		inout int wr_idx);
		for (int i = 0; i < int'(size); i++)
		begin
			@(posedge clk);
			avl_write_req <= 1'b1;
			avl_read_req  <= 1'b0;
			avl_addr      <= (i == 0) ? addr : memctl_pkg::addr_t'($urandom);
			avl_size      <= (i == 0) ? size : memctl_pkg::size_t'($urandom);
			avl_wdata     <= beat_word[wr_idx];
			exp_is_read.push_back(1'b0);
			exp_addr.push_back(addr + memctl_pkg::addr_t'(i));
			exp_enc.push_back(encode_word(beat_word[wr_idx]));
			// each beat is driven on its own edge, so its command is always two edges on
			exp_cycle.push_back(cycle + 2);
			wr_idx++;
		end
	endtask

	// one request cycle, then the bus stays idle while addresses are issued
	task automatic drive_read(input memctl_pkg::addr_t addr, input memctl_pkg::size_t size,
		inout int rd_idx);
		@(posedge clk);
		avl_read_req  <= 1'b1;
		avl_write_req <= 1'b0;
		avl_addr      <= addr;
		avl_size      <= size;
		for (int i = 0; i < int'(size); i++)
		begin
			exp_is_read.push_back(1'b1);
			exp_addr.push_back(addr + memctl_pkg::addr_t'(i));
			exp_enc.push_back('0);
			exp_cycle.push_back(cycle + 2 + i);
			mask_q.push_back(beat_mask[rd_idx]);
			exp_ret_data.push_back(beat_exp_data[rd_idx]);
			exp_ret_perr.push_back(beat_exp_perr[rd_idx]);
			rd_idx++;
		end
		repeat (int'(size) - 1) drive_idle();
	endtask

	initial
	begin
		int wr_idx;
		int rd_idx;
		int gap;
		wr_idx = 0;
		rd_idx = 0;
		void'($urandom(32'h10c7_17e4));
		load_trace();
		cycle_limit = 20 * beat_count + 16 * line_kind.size() + 100;
		do
		begin
			@(posedge clk);
		end
		while (rst);
		for (int l = 0; l < line_kind.size(); l++)
		begin
			// zero gap gives back-to-back bursts as soon as avl_ready allows
			gap = $urandom % 3;
			repeat (gap) drive_idle();
			if (line_kind[l] == "W")
			begin
				drive_write(line_addr[l], line_size[l], wr_idx);
			end
			else
			begin
				drive_read(line_addr[l], line_size[l], rd_idx);
			end
		end
		drive_idle();
		while (exp_cycle.size() != 0 || exp_ret_data.size() != 0)
		begin
			@(negedge clk);
		end
		// a few quiet cycles so stray strobes are still caught
		repeat (4) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// SRAM model, bus monitor and timeout
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin : sram_model
		memctl_pkg::enc_t word;
		memctl_pkg::enc_t mask;
		if (rst)
		begin
			s1_valid        <= 1'b0;
			s2_valid        <= 1'b0;
			mem_rdata_valid <= 1'b0;
		end
		else
		begin
			if (mem_write)
			begin
				sram[mem_addr] = mem_wdata;
			end
			word = '0;
			if (mem_read)
			begin
				if (mask_q.size() == 0)
				begin
					abort_run("the DUT issued a memory read that no burst asked for");
				end
				mask = mask_q.pop_front();
				if (sram.exists(mem_addr))
				begin
					word = sram[mem_addr];
				end
				word = word ^ mask;
			end
			// three edges from the command to mem_rdata_valid
			s1_valid        <= mem_read;
			s1_data         <= word;
			s2_valid        <= s1_valid;
			s2_data         <= s1_data;
			mem_rdata_valid <= s2_valid;
			mem_rdata       <= s2_data;
		end
	end

	// the first check after reset covers the idle state of every output
	always @(posedge clk)
	begin : bus_monitor
		if (!rst)
		begin
			check_flag("avl_ready", (ready_low_left == 0), avl_ready);
			if (ready_low_left > 0)
			begin
				ready_low_left = ready_low_left - 1;
			end
			if (avl_read_req)
			begin
				ready_low_left = int'(avl_size) - 1;
			end
			if (exp_cycle.size() != 0 && exp_cycle[0] == cycle)
			begin
				check_flag("mem_write", !exp_is_read[0], mem_write);
				check_flag("mem_read", exp_is_read[0], mem_read);
				check_addr("mem_addr", exp_addr[0], mem_addr);
				if (!exp_is_read[0])
				begin
					check_enc("mem_wdata", exp_enc[0], mem_wdata);
				end
				void'(exp_is_read.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_enc.pop_front());
				void'(exp_cycle.pop_front());
			end
			else
			begin
				check_flag("mem_write", 1'b0, mem_write);
				check_flag("mem_read", 1'b0, mem_read);
			end
			// read return trails the SRAM's valid by exactly one edge
			check_flag("avl_rdata_valid", prev_mem_valid, avl_rdata_valid);
			if (avl_rdata_valid)
			begin
				if (exp_ret_data.size() == 0)
				begin
					abort_run("the DUT returned read data that was never requested");
				end
				check_data("avl_rdata", exp_ret_data.pop_front(), avl_rdata);
				check_perr("avl_parity_error", exp_ret_perr.pop_front(), avl_parity_error);
			end
		end
		prev_mem_valid <= mem_rdata_valid;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		if (cycle > cycle_limit)
		begin
			abort_run($sformatf("timeout after %0d cycles, the trace did not complete", cycle));
		end
	end

endmodule

/* common/memctl_pkg.sv */
// widths are fixed here for a 4-byte word with 9-bit lanes; burst sizes of 1 to 7 only, size 0 is illegal
package memctl_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	// bytes per local-bus word, each byte gets its own parity bit
	localparam int NUM_BYTES = 4;

	// decoded width on the local bus
	localparam int DATA_WIDTH = NUM_BYTES * 8;

	// encoded width on the memory bus, eight data bits plus parity per lane
	localparam int ENC_WIDTH = NUM_BYTES * 9;

	// word address, one address per memory beat
	localparam int ADDR_WIDTH = 20;

	// burst size field, 1 to 7 beats
	localparam int SIZE_WIDTH = 3;

	//////////////////////////////////////////////////////////////////////
	// data types
	//////////////////////////////////////////////////////////////////////

	// a decoded word as seen by the local bus
	typedef logic [DATA_WIDTH-1:0] data_t;

	// an encoded word as stored in the SRAM
	typedef logic [ENC_WIDTH-1:0] enc_t;

	// a word address
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// a burst size in beats
	typedef logic [SIZE_WIDTH-1:0] size_t;

	// one error flag per byte lane of a read word
	typedef logic [NUM_BYTES-1:0] perr_t;

endpackage

/* data_if/memctl_data_if.sv */
// write bursts must be gapless and read return has no back-pressure; the master must sample avl_ready
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// local-bus front end
// takes bursts on the local bus and issues one memory command per beat
// on the next clock, with the address stepping by one each beat
//////////////////////////////////////////////////////////////////////

module memctl_data_if (
	input  logic                clk,
	input  logic                rst,
	input  logic                avl_write_req,
	input  logic                avl_read_req,
	input  memctl_pkg::addr_t   avl_addr,
	input  memctl_pkg::size_t   avl_size,
	input  memctl_pkg::data_t   avl_wdata,
	output logic                avl_ready,
	output logic                avl_rdata_valid,
	output memctl_pkg::data_t   avl_rdata,
	output memctl_pkg::perr_t   avl_parity_error,
	output logic                mem_write,
	output logic                mem_read,
	output memctl_pkg::addr_t   mem_addr,
	output memctl_pkg::data_t   enc_wdata,
	input  logic                dec_rdata_valid,
	input  memctl_pkg::data_t   dec_rdata,
	input  memctl_pkg::perr_t   dec_parity_error
);

	// burst state: a burst is open while more beats are still owed
	logic              burst_active;
	logic              burst_is_read;
	memctl_pkg::size_t beat_left;
	memctl_pkg::addr_t next_addr;

	// beat qualifiers for this cycle
	logic first_beat;
	logic cont_beat;

	//////////////////////////////////////////////////////////////////////
	// beat decode
	//////////////////////////////////////////////////////////////////////

	// a new burst can only open when nothing is pending
	assign first_beat = !burst_active && (avl_write_req || avl_read_req);

	// read beats after the first are generated here without the master,
	// write beats after the first follow the master's request strobe
	assign cont_beat = burst_active && (burst_is_read || avl_write_req);

	// the bus is only held off while read addresses are being issued
	assign avl_ready = !(burst_active && burst_is_read);

	//////////////////////////////////////////////////////////////////////
	// control state and command strobes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			burst_active  <= 1'b0;
			burst_is_read <= 1'b0;
			beat_left     <= '0;
			mem_write     <= 1'b0;
			mem_read      <= 1'b0;
		end
		else
		begin
			// strobes are single-cycle unless a beat is taken below
			mem_write <= 1'b0;
			mem_read  <= 1'b0;
			if (first_beat)
			begin
				mem_write     <= avl_write_req;
				mem_read      <= avl_read_req;
				burst_is_read <= avl_read_req;
				// the first beat is already spent, so count the rest
				beat_left     <= avl_size - 1'b1;
				burst_active  <= (avl_size > 3'd1);
			end
			else if (cont_beat)
			begin
				mem_write <= !burst_is_read;
				mem_read  <= burst_is_read;
				beat_left <= beat_left - 1'b1;
				// last owed beat closes the burst, ready rises next cycle
				if (beat_left == 3'd1)
				begin
					burst_active <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// address and write data path
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (first_beat)
		begin
			// avl_addr is only valid on the first beat of a burst
			mem_addr  <= avl_addr;
			next_addr <= avl_addr + 1'b1;
		end
		else if (cont_beat)
		begin
			mem_addr  <= next_addr;
			next_addr <= next_addr + 1'b1;
		end

		// the encoder sees the word that goes out with this mem_write
		if (avl_write_req)
		begin
			enc_wdata <= avl_wdata;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// read return, one register stage after the parity checker
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			avl_rdata_valid <= 1'b0;
		end
		else
		begin
			avl_rdata_valid <= dec_rdata_valid;
		end
	end

	// flags are already gated by valid in the checker, so they
	// line up with avl_rdata_valid without further qualification
	always_ff @(posedge clk)
	begin
		avl_rdata        <= dec_rdata;
		avl_parity_error <= dec_parity_error;
	end

	//////////////////////////////////////////////////////////////////////
	// bus protocol checks
	//////////////////////////////////////////////////////////////////////

	// while read addresses are issued nothing new may arrive
	a_req_when_ready: assert property (@(posedge clk) disable iff (rst)
		!avl_ready |-> !(avl_write_req || avl_read_req))
		else $error("request while avl_ready is low");

	// a burst of zero beats would leave the counter wrapping
	a_size_nonzero: assert property (@(posedge clk) disable iff (rst)
		first_beat |-> (avl_size != '0))
		else $error("burst size 0 on a first beat");

	// once a write burst opens, each following cycle must carry a beat
	a_write_no_gap: assert property (@(posedge clk) disable iff (rst)
		(burst_active && !burst_is_read) |-> (avl_write_req && !avl_read_req))
		else $error("gap or read request inside a write burst");

endmodule

/* hdl/memctl_parity.sv */
// purely combinational; lane count comes from memctl_pkg and even parity catches odd bit errors only
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// byte-lane parity
// write side appends the XOR of each byte as bit 8 of its lane, read
// side strips that bit and flags any lane whose nine bits XOR to one
//////////////////////////////////////////////////////////////////////

module memctl_parity (
	input  memctl_pkg::data_t  wdata_in,
	output memctl_pkg::enc_t   wdata_out,
	input  logic               rdata_valid,
	input  memctl_pkg::enc_t   rdata_in,
	output memctl_pkg::data_t  rdata_out,
	output memctl_pkg::perr_t  parity_error
);

	// the encoded layout assumes exactly nine bits per byte lane
	if (memctl_pkg::ENC_WIDTH != memctl_pkg::NUM_BYTES * 9)
	begin : g_enc_width_check
		$error("ENC_WIDTH does not match NUM_BYTES lanes of nine bits");
	end

	for (genvar i = 0; i < memctl_pkg::NUM_BYTES; i++)
	begin : g_lane
		// encode, data bits low and parity on top of each lane
		assign wdata_out[i*9 +: 8] = wdata_in[i*8 +: 8];
		assign wdata_out[i*9 + 8]  = ^wdata_in[i*8 +: 8];

		// decode, the data bits pass through even when parity is bad
		assign rdata_out[i*8 +: 8] = rdata_in[i*9 +: 8];

		// a good lane has even parity over all nine bits
		assign parity_error[i] = rdata_valid & (^rdata_in[i*9 +: 9]);
	end

endmodule

/* hdl/memctl_top.sv */
// memory side has no PHY; read data must come back in command order with one valid cycle per word
`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////
// controller data path top
// joins the local-bus front end to the parity block, the memory
// command and data pins leave from here unchanged
//////////////////////////////////////////////////////////////////////

module memctl_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                avl_write_req,
	input  logic                avl_read_req,
	input  memctl_pkg::addr_t   avl_addr,
	input  memctl_pkg::size_t   avl_size,
	input  memctl_pkg::data_t   avl_wdata,
	output logic                avl_ready,
	output logic                avl_rdata_valid,
	output memctl_pkg::data_t   avl_rdata,
	output memctl_pkg::perr_t   avl_parity_error,
	output logic                mem_write,
	output logic                mem_read,
	output memctl_pkg::addr_t   mem_addr,
	output memctl_pkg::enc_t    mem_wdata,
	input  logic                mem_rdata_valid,
	input  memctl_pkg::enc_t    mem_rdata
);

	// registered write word on its way into the encoder
	memctl_pkg::data_t enc_wdata;

	// decoded read word and lane flags before the return register
	memctl_pkg::data_t dec_rdata;
	memctl_pkg::perr_t dec_parity_error;

	memctl_data_if u_data_if (
		.clk              (clk),
		.rst              (rst),
		.avl_write_req    (avl_write_req),
		.avl_read_req     (avl_read_req),
		.avl_addr         (avl_addr),
		.avl_size         (avl_size),
		.avl_wdata        (avl_wdata),
		.avl_ready        (avl_ready),
		.avl_rdata_valid  (avl_rdata_valid),
		.avl_rdata        (avl_rdata),
		.avl_parity_error (avl_parity_error),
		.mem_write        (mem_write),
		.mem_read         (mem_read),
		.mem_addr         (mem_addr),
		.enc_wdata        (enc_wdata),
		.dec_rdata_valid  (mem_rdata_valid),
		.dec_rdata        (dec_rdata),
		.dec_parity_error (dec_parity_error)
	);

	// encoded write word lines up with the registered mem_write
	memctl_parity u_parity (
		.wdata_in     (enc_wdata),
		.wdata_out    (mem_wdata),
		.rdata_valid  (mem_rdata_valid),
		.rdata_in     (mem_rdata),
		.rdata_out    (dec_rdata),
		.parity_error (dec_parity_error)
	);

endmodule

/* project.f */
common/memctl_pkg.sv
hdl/memctl_parity.sv
data_if/memctl_data_if.sv
hdl/memctl_top.sv
bench/tb_clkgen.sv
bench/tb_memctl.sv
